// ==== xc_defs.svh ====
`ifndef XC_DEFS_SVH
`define XC_DEFS_SVH

`define XC_RV		16	// data word width
`define XC_REG_BITS	4	// register number width
`define XC_OP_BITS	4	// alu operation code width

// alu operation codes
`define XC_OP_ADD	4'd0
`define XC_OP_SUB	4'd1
`define XC_OP_XOR	4'd2
`define XC_OP_OR	4'd3
`define XC_OP_AND	4'd4
`define XC_OP_SLL	4'd5
`define XC_OP_SRA	4'd6
`define XC_OP_SRL	4'd7
`define XC_OP_ADDB	4'd8	// add, sign extend low byte
`define XC_OP_ADDBU	4'd9	// add, zero extend low byte
`define XC_OP_SWAP	4'd10	// byte swap of second operand

// architectural register numbers
`define XC_REG_ZERO	4'd0
`define XC_REG_LR	4'd1
`define XC_REG_SP	4'd2

`define XC_RESET_PC	15'd0	// word pc after reset

`endif

// ==== xc_pkg.sv ====
`default_nettype none

`include "xc_defs.svh"

package xc_pkg;

	// one decoded instruction
	typedef struct packed {
		logic [`XC_REG_BITS-1:0] rd;
		logic [`XC_REG_BITS-1:0] rs1;
		logic [`XC_REG_BITS-1:0] rs2;
		logic needs_rs2;
		logic rs2_pc;				// second operand is the pc
		logic rs2_inv;				// second operand is all ones
		logic [`XC_RV-1:0] imm;
		logic load;
		logic store;
		logic jmp;
		logic br;
		logic [`XC_OP_BITS-1:0] op;
		logic [2:0] cond;			// [0] byte or link, [2] unconditional
	} exec_op_t;

	// forwarded register values
	typedef struct packed {
		logic [`XC_RV-1:0] src1;
		logic [`XC_RV-1:0] src2;
	} operand_t;

	typedef struct packed {
		logic valid;
		logic [`XC_REG_BITS-1:0] reg_addr;
		logic [`XC_RV-1:0] data;	// also the load/store address
	} wb_t;

	typedef struct packed {
		logic [`XC_RV-1:0] result;
		logic [`XC_RV-1:1] target;	// word pc
		logic taken;
		logic link;
	} exec_result_t;

endpackage

`default_nettype wire

// ==== xc_reg_file.sv ====
`default_nettype none

`include "xc_defs.svh"

module xc_reg_file (
	input  logic clk,
	input  logic reset,
	input  logic [`XC_REG_BITS-1:0] rs1,
	input  logic [`XC_REG_BITS-1:0] rs2,
	input  xc_pkg::wb_t wb,
	output xc_pkg::operand_t operands
);
	import xc_pkg::*;

	logic [`XC_RV-1:1] r_lr;	// word aligned
	logic [`XC_RV-1:1] r_sp;
	logic [`XC_RV-1:0] r_gpr [8];	// registers 8 to 15

	function automatic logic [`XC_RV-1:0] read_reg(input logic [`XC_REG_BITS-1:0] num);
		logic [`XC_RV-1:0] v;
		logic implemented;
		v = '0;
		implemented = num[3] || num == `XC_REG_LR || num == `XC_REG_SP;
		if (num[3]) begin
			v = r_gpr[num[2:0]];
		end else if (num == `XC_REG_LR) begin
			v = {r_lr, 1'b0};
		end else if (num == `XC_REG_SP) begin
			v = {r_sp, 1'b0};
		end
		// bypass the item that has not been written yet
		if (wb.valid && wb.reg_addr == num && implemented) begin
			v = wb.data;
			if (!num[3])
				v[0] = 1'b0;	// lr and sp hold no bit 0
		end
		return v;
	endfunction

	always_comb begin
		operands = operand_t'{src1: read_reg(rs1), src2: read_reg(rs2)};
	end

	// lr and sp start at zero
	always_ff @(posedge clk) begin
		if (reset) begin
			r_lr <= '0;
			r_sp <= '0;
		end else if (wb.valid) begin
			case (wb.reg_addr)
			`XC_REG_LR:	r_lr <= wb.data[`XC_RV-1:1];
			`XC_REG_SP:	r_sp <= wb.data[`XC_RV-1:1];
			default:;	// 0 and 3..7 drop the write
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wb.valid && wb.reg_addr[3])
			r_gpr[wb.reg_addr[2:0]] <= wb.data;
	end

endmodule

`default_nettype wire

// ==== xc_alu.sv ====
`default_nettype none

`include "xc_defs.svh"

module xc_alu (
	input  xc_pkg::exec_op_t instr,
	input  xc_pkg::operand_t operands,
	input  logic [`XC_RV-1:1] pc,
	output xc_pkg::exec_result_t result
);
	import xc_pkg::*;

	logic [`XC_RV-1:0] op1;
	logic [`XC_RV-1:0] op2;
	logic [`XC_RV-1:0] sum;
	logic [`XC_RV-1:0] diff;
	logic [`XC_RV-1:0] alu_v;
	logic [4:0] shamt;
	logic cond_true;
	logic taken;
	logic link;

	// conditional branches are pc relative
	assign op1 = (instr.br && !instr.cond[2]) ? {pc, 1'b0} : operands.src1;

	always_comb begin
		if (instr.rs2_inv) begin
			op2 = '1;
		end else if (instr.rs2_pc) begin
			op2 = {pc, 1'b0};
		end else if (instr.needs_rs2) begin
			op2 = operands.src2;
		end else begin
			op2 = instr.imm;
		end
	end

	assign sum = op1 + op2;
	assign diff = op1 - op2;
	assign shamt = {~|op2[3:0], op2[3:0]};	// count 0 shifts by 16

	always_comb begin
		case (instr.op)
		`XC_OP_ADD:	alu_v = sum;
		`XC_OP_SUB:	alu_v = diff;
		`XC_OP_XOR:	alu_v = op1 ^ op2;
		`XC_OP_OR:	alu_v = op1 | op2;
		`XC_OP_AND:	alu_v = op1 & op2;
		`XC_OP_SLL:	alu_v = op1 << shamt;
		`XC_OP_SRA:	alu_v = $signed(op1) >>> shamt;
		`XC_OP_SRL:	alu_v = op1 >> shamt;
		`XC_OP_ADDB:	alu_v = {{8{sum[7]}}, sum[7:0]};
		`XC_OP_ADDBU:	alu_v = {8'h00, sum[7:0]};
		`XC_OP_SWAP:	alu_v = {op2[7:0], op2[15:8]};
		default:	alu_v = '0;
		endcase
	end

	// condition tests the register, not the pc operand
	always_comb begin
		case (instr.cond)
		3'b000:	cond_true = operands.src1 == '0;		// beqz
		3'b001:	cond_true = operands.src1 != '0;		// bnez
		3'b010:	cond_true = !operands.src1[`XC_RV-1];	// bgez
		3'b011:	cond_true = operands.src1[`XC_RV-1];	// bltz
		default:	cond_true = 1'b1;
		endcase
	end

	assign taken = instr.jmp || (instr.br && cond_true);
	assign link = ((instr.br && instr.cond[2]) || instr.jmp) && instr.cond[0];

	assign result = exec_result_t'{
		result: alu_v,
		target: sum[`XC_RV-1:1],
		taken: taken,
		link: link
	};

endmodule

`default_nettype wire

// ==== xc_control.sv ====
`default_nettype none

`include "xc_defs.svh"

module xc_control (
	input  logic clk,
	input  logic reset,
	input  logic iready,
	input  logic idone,
	input  logic rdone,
	input  logic wdone,
	input  xc_pkg::exec_op_t instr,
	input  xc_pkg::exec_result_t result,
	input  xc_pkg::wb_t wb,
	output logic issue,
	output logic [`XC_RV-1:1] pc,
	output logic [`XC_RV-1:1] pc_next,	// link value
	output logic ifetch,
	output logic [1:0] rstrobe,
	output logic [1:0] wmask
);
	import xc_pkg::*;

	logic r_fetch;
	logic r_load;		// read pending
	logic r_store;		// write pending
	logic r_byte;
	logic [`XC_RV-1:1] r_pc;
	logic [1:0] lanes;
	logic mem_op;

	// fetch answered with an instruction
	assign issue = r_fetch && idone && iready;
	assign mem_op = instr.load || instr.store;

	assign pc = r_pc;
	assign pc_next = r_pc + 1'b1;
	assign ifetch = r_fetch;

	// byte lane from address bit 0 held in the writeback register
	assign lanes = r_byte ? {wb.data[0], ~wb.data[0]} : 2'b11;
	assign rstrobe = r_load ? lanes : 2'b00;
	assign wmask = r_store ? lanes : 2'b00;

	always_ff @(posedge clk) begin
		if (reset) begin
			r_pc <= `XC_RESET_PC;
		end else if (issue) begin
			r_pc <= result.taken ? result.target : pc_next;
		end
	end

	// fetch pauses while a load or store is outstanding
	always_ff @(posedge clk) begin
		if (reset) begin
			r_fetch <= 1'b1;
		end else if (issue) begin
			r_fetch <= !mem_op;
		end else if ((r_load && rdone) || (r_store && wdone)) begin
			r_fetch <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			r_load <= 1'b0;
		end else if (issue) begin
			r_load <= instr.load;
		end else if (rdone) begin
			r_load <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			r_store <= 1'b0;
		end else if (issue) begin
			r_store <= instr.store;
		end else if (wdone) begin
			r_store <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (issue)
			r_byte <= instr.cond[0];
	end

endmodule

`default_nettype wire

// ==== xc_writeback.sv ====
`default_nettype none

`include "xc_defs.svh"

module xc_writeback (
	input  logic clk,
	input  logic reset,
	input  logic issue,
	input  xc_pkg::exec_op_t instr,
	input  xc_pkg::operand_t operands,
	input  xc_pkg::exec_result_t result,
	input  logic [`XC_RV-1:1] pc_next,
	input  logic rdone,
	input  logic [`XC_RV-1:0] rdata,
	output xc_pkg::wb_t wb,
	output logic [`XC_RV-1:0] wdata
);
	import xc_pkg::*;

	logic r_byte;
	logic writes_rd;
	logic [`XC_RV-1:0] load_v;

	// loads write on rdone, branches only when they link
	assign writes_rd = !(instr.load || instr.store) &&
		(!(instr.br || instr.jmp) || result.link);

	assign load_v = r_byte ? {{8{rdata[7]}}, rdata[7:0]} : rdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			wb.valid <= 1'b0;
		end else if (issue) begin
			wb <= wb_t'{
				valid: writes_rd,
				reg_addr: instr.rd,
				data: result.link ? {pc_next, 1'b0} : result.result
			};
		end else if (rdone) begin
			wb.valid <= 1'b1;
			wb.data <= load_v;
		end else begin
			wb.valid <= 1'b0;	// one cycle pulse
		end
	end

	// store data, byte replicated in both lanes
	always_ff @(posedge clk) begin
		if (issue) begin
			r_byte <= instr.cond[0];
			wdata <= instr.cond[0] ? {2{operands.src2[7:0]}} : operands.src2;
		end
	end

endmodule

`default_nettype wire

// ==== xc_execute.sv ====
`default_nettype none

`include "xc_defs.svh"

module xc_execute (
	input  logic clk,
	input  logic reset,
	input  logic iready,
	input  xc_pkg::exec_op_t instr,
	output logic [`XC_RV-1:1] pc,
	output logic ifetch,
	input  logic idone,
	output logic [`XC_RV-1:1] addr,
	output logic [`XC_RV-1:0] wdata,
	output logic [1:0] wmask,
	output logic [1:0] rstrobe,
	input  logic [`XC_RV-1:0] rdata,
	input  logic rdone,
	input  logic wdone
);
	import xc_pkg::*;

	operand_t operands;
	exec_result_t result;
	wb_t wb;
	logic issue;
	logic [`XC_RV-1:1] pc_next;

	assign addr = wb.data[`XC_RV-1:1];	// word address of the access

	xc_reg_file u_reg_file (
		.clk(clk),
		.reset(reset),
		.rs1(instr.rs1),
		.rs2(instr.rs2),
		.wb(wb),
		.operands(operands)
	);

	xc_alu u_alu (
		.instr(instr),
		.operands(operands),
		.pc(pc),
		.result(result)
	);

	xc_control u_control (
		.clk(clk),
		.reset(reset),
		.iready(iready),
		.idone(idone),
		.rdone(rdone),
		.wdone(wdone),
		.instr(instr),
		.result(result),
		.wb(wb),
		.issue(issue),
		.pc(pc),
		.pc_next(pc_next),
		.ifetch(ifetch),
		.rstrobe(rstrobe),
		.wmask(wmask)
	);

	xc_writeback u_writeback (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.instr(instr),
		.operands(operands),
		.result(result),
		.pc_next(pc_next),
		.rdone(rdone),
		.rdata(rdata),
		.wb(wb),
		.wdata(wdata)
	);

endmodule

`default_nettype wire

// ==== xc_execute_chk.sv ====
`default_nettype none

module xc_execute_chk (
	input logic clk,
	input logic reset,
	input logic ifetch,
	input logic [1:0] wmask,
	input logic [1:0] rstrobe,
	input logic rdone
);
	timeunit 1ns;
	timeprecision 1ps;

	a_no_read_and_write: assert property (@(posedge clk) disable iff (reset)
		!(|wmask && |rstrobe))
		else $error("read strobe and write mask active together");

	a_no_fetch_during_write: assert property (@(posedge clk) disable iff (reset)
		!(ifetch && |wmask))
		else $error("ifetch high with a nonzero wmask");

	// read strobe stays up until answered
	a_rstrobe_held: assert property (@(posedge clk) disable iff (reset)
		(|rstrobe && !rdone) |=> |rstrobe)
		else $error("rstrobe dropped before rdone");

	a_wmask_after_reset: assert property (@(posedge clk)
		reset |=> wmask == 2'b00)
		else $error("wmask nonzero after reset");

endmodule

bind xc_execute xc_execute_chk u_chk (
	.clk(clk),
	.reset(reset),
	.ifetch(ifetch),
	.wmask(wmask),
	.rstrobe(rstrobe),
	.rdone(rdone)
);

`default_nettype wire

// ==== tb_xc_execute.sv ====
`default_nettype none

`include "xc_defs.svh"

module tb_xc_execute;
	timeunit 1ns;
	timeprecision 1ps;
	import xc_pkg::*;

	typedef struct packed {
		exec_op_t instr;
		logic [15:0] rdata;		// returned on rdone
		logic [1:0] delay;		// cycles before rdone or wdone
		logic [15:1] exp_pc;
		logic [15:1] exp_addr;
		logic [15:0] exp_wdata;
		logic [1:0] exp_wmask;
		logic [1:0] exp_rstrobe;
	} row_t;

	logic clk = 1'b0;
	logic reset;
	logic iready;
	logic idone;
	exec_op_t instr;
	logic [15:1] pc;
	logic ifetch;
	logic [15:1] addr;
	logic [15:0] wdata;
	logic [1:0] wmask;
	logic [1:0] rstrobe;
	logic [15:0] rdata;
	logic rdone;
	logic wdone;

	row_t rows[$];
	int n_rows = 0;
	int errors = 0;
	int n_pass = 0;
	int n_fail = 0;

	xc_execute u_dut (
		.clk(clk), .reset(reset), .iready(iready), .instr(instr),
		.pc(pc), .ifetch(ifetch), .idone(idone),
		.addr(addr), .wdata(wdata), .wmask(wmask), .rstrobe(rstrobe),
		.rdata(rdata), .rdone(rdone), .wdone(wdone)
	);

	always #5 clk = ~clk;

	task automatic mismatch(input string what, input logic [15:0] got, input logic [15:0] exp);
		errors++;
		$display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
	endtask

	task automatic push_row(input exec_op_t op, input logic [15:0] rd_data,
			input logic [1:0] dly, input logic [15:1] nxt, input logic [15:1] a,
			input logic [15:0] wd, input logic [1:0] wm, input logic [1:0] rs);
		row_t r;
		r = '{instr: op, rdata: rd_data, delay: dly, exp_pc: nxt, exp_addr: a,
			exp_wdata: wd, exp_wmask: wm, exp_rstrobe: rs};
		rows.push_back(r);
	endtask

	task automatic alu_row(input logic [3:0] op, input logic [3:0] rd, input logic [3:0] rs1,
			input logic [3:0] rs2, input logic use_rs2, input logic [15:0] imm,
			input logic [15:1] nxt);
		exec_op_t i;
		i = '0;
		i.op = op;
		i.rd = rd;
		i.rs1 = rs1;
		i.rs2 = rs2;
		i.needs_rs2 = use_rs2;
		i.imm = imm;
		push_row(i, 16'h0, 2'd0, nxt, '0, '0, '0, '0);
	endtask

	// address is r0 plus imm
	task automatic store_row(input logic [3:0] rs2, input logic [15:0] imm, input logic is_byte,
			input logic [1:0] dly, input logic [15:1] nxt, input logic [15:0] wd,
			input logic [1:0] wm);
		exec_op_t i;
		i = '0;
		i.store = 1'b1;
		i.rs2 = rs2;
		i.imm = imm;
		i.cond = {2'b00, is_byte};
		push_row(i, 16'h0, dly, nxt, imm[15:1], wd, wm, 2'b00);
	endtask

	task automatic load_row(input logic [3:0] rd, input logic [15:0] imm, input logic is_byte,
			input logic [15:0] rd_data, input logic [1:0] dly, input logic [15:1] nxt,
			input logic [1:0] rs);
		exec_op_t i;
		i = '0;
		i.load = 1'b1;
		i.rd = rd;
		i.imm = imm;
		i.cond = {2'b00, is_byte};
		push_row(i, rd_data, dly, nxt, imm[15:1], 16'h0, 2'b00, rs);
	endtask

	task automatic flow_row(input logic is_jmp, input logic [2:0] cond, input logic [3:0] rd,
			input logic [3:0] rs1, input logic [15:0] imm, input logic [15:1] nxt);
		exec_op_t i;
		i = '0;
		i.jmp = is_jmp;
		i.br = !is_jmp;
		i.cond = cond;
		i.rd = rd;
		i.rs1 = rs1;
		i.imm = imm;
		push_row(i, 16'h0, 2'd0, nxt, '0, '0, '0, '0);
	endtask

	task automatic build_table();
		alu_row(`XC_OP_ADD, 8, 0, 0, 0, 16'h1234, 15'h01);
		alu_row(`XC_OP_ADD, 9, 0, 0, 0, 16'h00F3, 15'h02);
		alu_row(`XC_OP_ADD, 10, 0, 0, 0, 16'h0004, 15'h03);	// shift count
		alu_row(`XC_OP_ADD, 11, 8, 9, 1, 16'h0, 15'h04);
		store_row(11, 16'h0100, 0, 0, 15'h05, 16'h1327, 2'b11);
		alu_row(`XC_OP_SUB, 11, 8, 9, 1, 16'h0, 15'h06);
		store_row(11, 16'h0102, 0, 0, 15'h07, 16'h1141, 2'b11);
		alu_row(`XC_OP_XOR, 11, 8, 9, 1, 16'h0, 15'h08);
		store_row(11, 16'h0104, 0, 0, 15'h09, 16'h12C7, 2'b11);
		alu_row(`XC_OP_OR, 11, 8, 9, 1, 16'h0, 15'h0A);
		store_row(11, 16'h0106, 0, 0, 15'h0B, 16'h12F7, 2'b11);
		alu_row(`XC_OP_AND, 11, 8, 9, 1, 16'h0, 15'h0C);
		store_row(11, 16'h0108, 0, 0, 15'h0D, 16'h0030, 2'b11);
		alu_row(`XC_OP_SLL, 11, 8, 10, 1, 16'h0, 15'h0E);
		store_row(11, 16'h010A, 0, 0, 15'h0F, 16'h2340, 2'b11);
		alu_row(`XC_OP_ADD, 12, 0, 0, 0, 16'h8010, 15'h10);	// negative value
		alu_row(`XC_OP_SRA, 11, 12, 10, 1, 16'h0, 15'h11);
		store_row(11, 16'h010C, 0, 0, 15'h12, 16'hF801, 2'b11);
		alu_row(`XC_OP_SRL, 11, 12, 10, 1, 16'h0, 15'h13);
		store_row(11, 16'h010E, 0, 0, 15'h14, 16'h0801, 2'b11);
		alu_row(`XC_OP_ADDB, 11, 8, 0, 0, 16'h0050, 15'h15);
		store_row(11, 16'h0110, 0, 0, 15'h16, 16'hFF84, 2'b11);
		alu_row(`XC_OP_ADDBU, 11, 8, 0, 0, 16'h0050, 15'h17);
		store_row(11, 16'h0112, 0, 0, 15'h18, 16'h0084, 2'b11);
		alu_row(`XC_OP_SWAP, 11, 0, 8, 1, 16'h0, 15'h19);
		store_row(11, 16'h0114, 0, 0, 15'h1A, 16'h3412, 2'b11);
		// dependent chain through the forwarding path
		alu_row(`XC_OP_ADD, 13, 0, 0, 0, 16'h0005, 15'h1B);
		alu_row(`XC_OP_ADD, 13, 13, 13, 1, 16'h0, 15'h1C);
		alu_row(`XC_OP_SUB, 14, 13, 0, 0, 16'h0003, 15'h1D);
		store_row(14, 16'h0116, 0, 0, 15'h1E, 16'h0007, 2'b11);
		flow_row(0, 3'b000, 0, 0, 16'h0008, 15'h22);	// beqz taken
		flow_row(0, 3'b001, 0, 0, 16'h0008, 15'h23);	// bnez not taken
		flow_row(0, 3'b011, 0, 12, 16'h0006, 15'h26);	// bltz taken
		flow_row(0, 3'b010, 0, 12, 16'h0004, 15'h27);	// bgez not taken
		flow_row(1, 3'b001, 15, 0, 16'h00A0, 15'h50);	// jump with link
		store_row(15, 16'h0118, 0, 0, 15'h51, 16'h0050, 2'b11);
		flow_row(0, 3'b101, 1, 8, 16'h0002, 15'h091B);	// uncond branch, link to lr
		store_row(1, 16'h011A, 0, 0, 15'h091C, 16'h00A4, 2'b11);
		load_row(9, 16'h0200, 0, 16'hBEEF, 1, 15'h091D, 2'b11);
		store_row(9, 16'h011C, 0, 0, 15'h091E, 16'hBEEF, 2'b11);
		load_row(9, 16'h0201, 1, 16'h0080, 2, 15'h091F, 2'b10);
		store_row(9, 16'h011E, 0, 0, 15'h0920, 16'hFF80, 2'b11);
		load_row(10, 16'h0202, 1, 16'h1234, 0, 15'h0921, 2'b01);
		store_row(10, 16'h0121, 1, 3, 15'h0922, 16'h3434, 2'b10);
		store_row(9, 16'h0120, 1, 0, 15'h0923, 16'h8080, 2'b01);
		store_row(12, 16'h0122, 0, 2, 15'h0924, 16'h8010, 2'b11);
	endtask

	task automatic finish_test(input string name, input int err_start);
		if (errors == err_start) begin
			n_pass++;
			$display("test %s ok", name);
		end else begin
			n_fail++;
			$display("test %s failed", name);
		end
	endtask

	task automatic check_pc(input logic [15:1] exp);
		if (ifetch !== 1'b1)
			mismatch("ifetch", {15'h0, ifetch}, 16'h1);
		if (pc !== exp)
			mismatch("pc", {1'b0, pc}, {1'b0, exp});
	endtask

	task automatic serve_memory(input row_t cur);
		do @(posedge clk); while (rstrobe == 2'b00 && wmask == 2'b00);
		if (addr !== cur.exp_addr)
			mismatch("addr", {1'b0, addr}, {1'b0, cur.exp_addr});
		if (cur.instr.load) begin
			if (rstrobe !== cur.exp_rstrobe)
				mismatch("rstrobe", {14'h0, rstrobe}, {14'h0, cur.exp_rstrobe});
		end else begin
			if (wmask !== cur.exp_wmask)
				mismatch("wmask", {14'h0, wmask}, {14'h0, cur.exp_wmask});
			if (wdata !== cur.exp_wdata)
				mismatch("wdata", wdata, cur.exp_wdata);
		end
		repeat (cur.delay) begin
			@(posedge clk);
			if (ifetch !== 1'b0)
				mismatch("ifetch during access", {15'h0, ifetch}, 16'h0);
		end
		if (cur.instr.load) begin
			rdone <= 1'b1;
			rdata <= cur.rdata;
		end else begin
			wdone <= 1'b1;
		end
		@(posedge clk);
		rdone <= 1'b0;
		wdone <= 1'b0;
		do @(posedge clk); while (!ifetch);
	endtask

	initial begin
		@(posedge clk);
		wait (n_rows > 0);
		repeat (n_rows * 20) @(posedge clk);
		$display("timeout: the DUT stopped answering before all tests ran");
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		row_t cur;
		logic [15:1] exp_pc;
		int err_start;
		logic last_mem;
		reset = 1'b1;
		iready = 1'b0;
		idone = 1'b0;
		instr = '0;
		rdata = '0;
		rdone = 1'b0;
		wdone = 1'b0;
		build_table();
		n_rows = rows.size();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		err_start = errors;
		check_pc(`XC_RESET_PC);
		if (wmask !== 2'b00 || rstrobe !== 2'b00)
			mismatch("strobes after reset", {12'h0, wmask, rstrobe}, 16'h0);
		finish_test("reset", err_start);
		exp_pc = `XC_RESET_PC;
		last_mem = 1'b0;
		for (int i = 0; i < n_rows; i++) begin
			cur = rows[i];
			instr <= cur.instr;
			idone <= 1'b1;
			iready <= 1'b1;
			@(posedge clk);	// issue edge
			check_pc(exp_pc);
			if (i > 0)
				finish_test($sformatf("row %0d", i - 1), err_start);
			err_start = errors;
			exp_pc = cur.exp_pc;
			last_mem = cur.instr.load || cur.instr.store;
			if (last_mem) begin
				idone <= 1'b0;
				iready <= 1'b0;
				serve_memory(cur);
			end
		end
		idone <= 1'b0;
		iready <= 1'b0;
		if (!last_mem)
			@(posedge clk);
		check_pc(exp_pc);
		finish_test($sformatf("row %0d", n_rows - 1), err_start);
		$display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== xc_execute.f ====
+incdir+.
xc_pkg.sv
xc_reg_file.sv
xc_alu.sv
xc_control.sv
xc_writeback.sv
xc_execute.sv
xc_execute_chk.sv
tb_xc_execute.sv

// ==== Bender.yml ====
package:
  name: xc_execute

export_include_dirs:
  - .

sources:
  - xc_pkg.sv
  - xc_reg_file.sv
  - xc_alu.sv
  - xc_control.sv
  - xc_writeback.sv
  - xc_execute.sv
  - target: test
    files:
      - xc_execute_chk.sv
      - tb_xc_execute.sv
